// File: design/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Cache geometry
`define CACHE_LINE_BYTES 16
`define CACHE_SETS       8
`define CACHE_WAYS       2

// Backing memory
`define MEM_LINES        256  // Selected by address bits 11 to 4
`define MEM_LATENCY      4    // Cycles from acceptance to response

`endif

// File: design/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

  // Processor request, sampled when valid and ready are both high
  typedef struct packed {
    logic        valid;
    logic        write;  // Low for a read
    logic [31:0] addr;
    logic [31:0] wdata;
  } cache_req_t;

  // Processor response, a single-cycle pulse
  typedef struct packed {
    logic        valid;
    logic        hit;
    logic [31:0] rdata;
  } cache_resp_t;

  // Word address as seen by the cache
  typedef struct packed {
    logic [24:0] tag;
    logic [2:0]  index;     // Set select
    logic [1:0]  word;      // Word within the line
    logic [1:0]  byte_off;  // Ignored, word access only
  } addr_fields_t;

  typedef logic [`CACHE_LINE_BYTES*8-1:0] line_t;

  typedef logic way_t;

endpackage

// File: design/mem_pkg.sv
`include "cache_defines.svh"

package mem_pkg;

  // One line-wide transfer, read or write
  typedef struct packed {
    logic                          valid;
    logic                          write;
    logic [31:0]                   addr;  // Byte address of the line
    logic [`CACHE_LINE_BYTES*8-1:0] line;
  } mem_req_t;

  // Completion pulse, carries read data
  typedef struct packed {
    logic                          valid;
    logic [`CACHE_LINE_BYTES*8-1:0] line;
  } mem_resp_t;

endpackage

// File: design/cache_tag_array.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_tag_array (
  input  logic                    clk,
  input  logic                    reset,
  input  cache_pkg::addr_fields_t lookup_addr,
  input  logic                    touch,
  input  cache_pkg::way_t         touch_way,
  input  logic                    fill,
  input  logic                    fill_dirty,
  input  logic                    word_write,
  output logic                    hit,
  output cache_pkg::way_t         hit_way,
  output cache_pkg::way_t         victim_way,
  output logic                    victim_dirty,
  output logic [24:0]             victim_tag
);
  import cache_pkg::*;

  logic [24:0]                             tags [`CACHE_SETS][`CACHE_WAYS];
  logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] valid_bits;
  logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] dirty_bits;
  logic [`CACHE_SETS-1:0]                  lru_bits;  // Holds the least recent way of each set
  way_t                                    lru_way;

  assign lru_way = lru_bits[lookup_addr.index];

  // Parallel tag compare across the ways
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (valid_bits[lookup_addr.index][w] && tags[lookup_addr.index][w] == lookup_addr.tag) begin
        hit     = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  // Lowest invalid way wins, else the LRU way
  always_comb begin
    victim_way = lru_way;
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_bits[lookup_addr.index][w])
        victim_way = way_t'(w);
    end
  end

  assign victim_dirty = dirty_bits[lookup_addr.index][victim_way];
  assign victim_tag   = tags[lookup_addr.index][victim_way];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
      lru_bits   <= '0;  // Way 0 goes first
    end else begin
      if (fill) begin
        valid_bits[lookup_addr.index][victim_way] <= 1'b1;
        dirty_bits[lookup_addr.index][victim_way] <= fill_dirty;  // Set on a write miss
      end
      if (word_write)
        dirty_bits[lookup_addr.index][hit_way] <= 1'b1;
      // With two ways the other way becomes LRU
      if (touch)
        lru_bits[lookup_addr.index] <= ~touch_way;
    end
  end

  always_ff @(posedge clk) begin
    if (fill)
      tags[lookup_addr.index][victim_way] <= lookup_addr.tag;
  end

endmodule

// File: design/cache_data_array.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_data_array (
  input  logic                    clk,
  input  cache_pkg::addr_fields_t lookup_addr,
  input  cache_pkg::way_t         hit_way,
  input  cache_pkg::way_t         victim_way,
  input  logic                    fill,
  input  cache_pkg::line_t        fill_line,
  input  logic                    word_write,
  input  logic [31:0]             word_data,
  output logic [31:0]             rd_word,
  output cache_pkg::line_t        rd_line
);
  import cache_pkg::*;

  line_t lines [`CACHE_SETS][`CACHE_WAYS];
  line_t hit_line;

  assign hit_line = lines[lookup_addr.index][hit_way];
  assign rd_word  = hit_line[lookup_addr.word*32 +: 32];  // Word at the offset

  // Whole victim line for the write-back
  assign rd_line = lines[lookup_addr.index][victim_way];

  always_ff @(posedge clk) begin
    if (fill) begin
      lines[lookup_addr.index][victim_way] <= fill_line;
    end else if (word_write) begin
      lines[lookup_addr.index][hit_way][lookup_addr.word*32 +: 32] <= word_data;
    end
  end

endmodule

// File: design/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  cache_pkg::cache_req_t   req,
  output logic                    ready,
  output cache_pkg::cache_resp_t  resp,
  input  logic                    hit,
  input  cache_pkg::way_t         hit_way,
  input  cache_pkg::way_t         victim_way,
  input  logic                    victim_dirty,
  input  logic [24:0]             victim_tag,
  input  logic [31:0]             rd_word,
  input  cache_pkg::line_t        rd_line,
  output cache_pkg::addr_fields_t lookup_addr,
  output logic                    touch,
  output cache_pkg::way_t         touch_way,
  output logic                    fill,
  output cache_pkg::line_t        fill_line,
  output logic                    fill_dirty,
  output logic                    word_write,
  output logic [31:0]             word_data,
  output mem_pkg::mem_req_t       mem_req,
  input  mem_pkg::mem_resp_t      mem_resp,
  input  logic                    mem_ready
);
  import cache_pkg::*;

  localparam int line_off_w = $clog2(`CACHE_LINE_BYTES);

  typedef enum logic [2:0] {
    s_compare,
    s_evict,
    s_write_back,
    s_allocate,
    s_wait
  } state_t;

  state_t       state;
  cache_req_t   req_q;      // Request held across a miss
  addr_fields_t miss_addr;
  logic         refill_q;   // Wait state belongs to a refill
  logic         accept;
  logic         mem_accept;
  logic         refill_done;
  line_t        merged_line;

  assign ready  = (state == s_compare);
  assign accept = req.valid && ready;

  // Live request during compare, held request afterwards
  assign miss_addr   = addr_fields_t'(req_q.addr);
  assign lookup_addr = ready ? addr_fields_t'(req.addr) : miss_addr;

  assign mem_accept  = mem_req.valid && mem_ready;
  assign refill_done = (state == s_wait) && refill_q && mem_resp.valid;

  // Hits and fills both refresh LRU
  assign touch      = (accept && hit) || refill_done;
  assign touch_way  = refill_done ? victim_way : hit_way;
  assign word_write = accept && hit && req.write;
  assign word_data  = req.wdata;

  // Write miss data lands in the refilled line
  always_comb begin
    merged_line = mem_resp.line;
    if (req_q.write)
      merged_line[miss_addr.word*32 +: 32] = req_q.wdata;
  end

  assign fill       = refill_done;
  assign fill_line  = merged_line;
  assign fill_dirty = req_q.write;

  always_comb begin
    mem_req = '0;
    case (state)
      s_write_back: begin
        mem_req.valid = 1'b1;
        mem_req.write = 1'b1;
        mem_req.addr  = {victim_tag, miss_addr.index, {line_off_w{1'b0}}};
        mem_req.line  = rd_line;
      end
      s_allocate: begin
        mem_req.valid = 1'b1;
        mem_req.addr  = {miss_addr.tag, miss_addr.index, {line_off_w{1'b0}}};
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= s_compare;
      refill_q   <= 1'b0;
      resp.valid <= 1'b0;
    end else begin
      resp.valid <= 1'b0;  // Single-cycle pulse
      case (state)
        s_compare: begin
          if (accept) begin
            req_q <= req;
            if (hit) begin
              resp.valid <= 1'b1;
              resp.hit   <= 1'b1;
              resp.rdata <= req.write ? req.wdata : rd_word;
            end else begin
              state <= s_evict;
            end
          end
        end
        s_evict: state <= victim_dirty ? s_write_back : s_allocate;
        s_write_back: begin
          if (mem_accept) begin
            refill_q <= 1'b0;
            state    <= s_wait;
          end
        end
        s_allocate: begin
          if (mem_accept) begin
            refill_q <= 1'b1;
            state    <= s_wait;
          end
        end
        s_wait: begin
          if (mem_resp.valid && refill_q) begin
            resp.valid <= 1'b1;
            resp.hit   <= 1'b0;
            resp.rdata <= merged_line[miss_addr.word*32 +: 32];
            state      <= s_compare;
          end else if (mem_resp.valid) begin
            state <= s_allocate;  // Write-back done, fetch the new line
          end
        end
        default: state <= s_compare;
      endcase
    end
  end

endmodule

// File: design/data_memory.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module data_memory (
  input  logic               clk,
  input  logic               reset,
  input  mem_pkg::mem_req_t  mem_req,
  output logic               mem_ready,
  output mem_pkg::mem_resp_t mem_resp
);
  import mem_pkg::*;

  localparam int line_off_w = $clog2(`CACHE_LINE_BYTES);
  localparam int index_w    = $clog2(`MEM_LINES);
  localparam int count_w    = $clog2(`MEM_LATENCY) + 1;

  logic [`CACHE_LINE_BYTES*8-1:0] lines [`MEM_LINES] = '{default: '0};

  mem_req_t                       pending;  // Captured request
  logic                           busy;
  logic [count_w-1:0]             count;
  logic                           done;
  logic                           resp_valid;
  logic [`CACHE_LINE_BYTES*8-1:0] resp_line;
  logic [index_w-1:0]             line_index;

  assign mem_ready  = !busy;
  assign line_index = pending.addr[line_off_w +: index_w];

  // Last busy cycle, response visible on the next one
  assign done = busy && (count == count_w'(1));

  assign mem_resp.valid = resp_valid;
  assign mem_resp.line  = resp_line;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      count      <= '0;
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= done;
      if (!busy && mem_req.valid) begin
        busy  <= 1'b1;
        count <= count_w'(`MEM_LATENCY - 1);
      end else if (done) begin
        busy <= 1'b0;
      end else if (busy) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && mem_req.valid)
      pending <= mem_req;
    if (done) begin
      resp_line <= lines[line_index];
      if (pending.write)
        lines[line_index] <= pending.line;
    end
  end

endmodule

// File: design/cache_top.sv
`timescale 1ns/1ps

module cache_top (
  input  logic                   clk,
  input  logic                   reset,
  input  cache_pkg::cache_req_t  req,
  output logic                   ready,
  output cache_pkg::cache_resp_t resp
);
  import cache_pkg::*;
  import mem_pkg::*;

  // Array side
  addr_fields_t lookup_addr;
  logic         hit;
  way_t         hit_way;
  way_t         victim_way;
  logic         victim_dirty;
  logic [24:0]  victim_tag;
  logic [31:0]  rd_word;
  line_t        rd_line;
  logic         touch;
  way_t         touch_way;
  logic         fill;
  line_t        fill_line;
  logic         fill_dirty;
  logic         word_write;
  logic [31:0]  word_data;

  // Memory side
  mem_req_t     mem_req;
  mem_resp_t    mem_resp;
  logic         mem_ready;

  // Port names match the nets above one to one
  cache_ctrl u_ctrl (.*);

  cache_tag_array u_tags (.*);

  cache_data_array u_data (.*);

  data_memory u_mem (.*);

endmodule

// File: testbench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: testbench/cache_tb.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_tb;
  import cache_pkg::*;

  localparam int wait_limit = 50;
  localparam int mem_words  = `MEM_LINES * `CACHE_LINE_BYTES / 4;

  logic        clk;
  logic        reset;
  cache_req_t  req;
  logic        ready;
  cache_resp_t resp;
  logic        accepted;
  logic        exp_hit;
  logic [31:0] exp_rdata;
  logic [15:0] lfsr;
  int          errors = 0;
  int          passed = 0;
  int          failed = 0;
  int          test_start_errors = 0;

  // Shadow of the cache state and of the memory as the processor sees it
  logic        sh_valid [`CACHE_SETS][`CACHE_WAYS];
  logic [24:0] sh_tag [`CACHE_SETS][`CACHE_WAYS];
  logic        sh_lru [`CACHE_SETS];  // Least recent way
  logic [31:0] sh_mem [mem_words];

  clock_gen clock_gen_i (.clk(clk), .reset(reset));

  cache_top dut (.clk(clk), .reset(reset), .req(req), .ready(ready), .resp(resp));

  assign accepted = req.valid && ready;

  task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] want);
    errors = errors + 1;
    $display("Fail at %0t: %s got %0h, expected %0h", $time, name, got, want);
  endtask

  task automatic report_problem(input string what);
    errors = errors + 1;
    $display("Problem at %0t: %s", $time, what);
  endtask

  rdata_matches: assert property (@(posedge clk) disable iff (reset)
    resp.valid |-> resp.rdata == exp_rdata)
    else report_value("resp.rdata", $sampled(resp.rdata), $sampled(exp_rdata));

  hit_matches: assert property (@(posedge clk) disable iff (reset)
    resp.valid |-> resp.hit == exp_hit)
    else report_value("resp.hit", $sampled(resp.hit), $sampled(exp_hit));

  // A hit answers on the very next cycle, a miss never does
  hit_latency: assert property (@(posedge clk) disable iff (reset)
    accepted && exp_hit |=> resp.valid)
    else report_problem("hit response did not come one cycle after acceptance");

  miss_latency: assert property (@(posedge clk) disable iff (reset)
    accepted && !exp_hit |=> !resp.valid)
    else report_problem("miss was answered one cycle after acceptance");

  single_pulse: assert property (@(posedge clk) disable iff (reset)
    resp.valid |=> !resp.valid)
    else report_problem("response valid stayed high for more than one cycle");

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else report_value(name, got, want);
  endtask

  task automatic abort_run(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Errors found");
    $finish;
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic model_hit(input logic [31:0] a);
    logic found;
    found = 1'b0;
    for (int w = 0; w < `CACHE_WAYS; w++)
      if (sh_valid[a[6:4]][w] && sh_tag[a[6:4]][w] == a[31:7])
        found = 1'b1;
    return found;
  endfunction

  // Hit refreshes LRU, miss fills an invalid way first, else the LRU way
  task automatic update_model(input logic w, input logic [31:0] a, input logic [31:0] d);
    logic [2:0] set;
    int         way;
    set = a[6:4];
    way = -1;
    for (int i = 0; i < `CACHE_WAYS; i++)
      if (sh_valid[set][i] && sh_tag[set][i] == a[31:7])
        way = i;
    if (way < 0) begin
      if (!sh_valid[set][0]) way = 0;
      else if (!sh_valid[set][1]) way = 1;
      else way = int'(sh_lru[set]);
      sh_valid[set][way] = 1'b1;
      sh_tag[set][way]   = a[31:7];
    end
    sh_lru[set] = (way == 0);
    if (w)
      sh_mem[a[11:2]] = d;
  endtask

  task automatic access(input logic w, input logic [31:0] a, input logic [31:0] d);
    int n;
    @(posedge clk);
    req       <= '{valid: 1'b1, write: w, addr: a, wdata: d};
    exp_hit   <= model_hit(a);
    exp_rdata <= w ? d : sh_mem[a[11:2]];
    n = 0;
    @(negedge clk);
    while (!ready) begin
      if (n == wait_limit) abort_run("ready stayed low");
      n++;
      @(negedge clk);
    end
    @(posedge clk);  // Acceptance edge
    req <= '0;
    n = 0;
    @(negedge clk);
    while (!resp.valid) begin
      if (n == wait_limit) abort_run("no response arrived");
      n++;
      @(negedge clk);
    end
    update_model(w, a, d);
  endtask

  task automatic end_test(input int num, input string name);
    repeat (2) @(negedge clk);  // Last response checks fire meanwhile
    if (errors == test_start_errors) begin
      passed++;
      $display("Test %0d %s: passed", num, name);
    end else begin
      failed++;
      $display("Test %0d %s: failed", num, name);
    end
    test_start_errors = errors;
  endtask

  initial begin
    logic [31:0] r;
    logic        w;
    logic [31:0] a;
    logic [31:0] d;
    int          n;
    req       = '0;
    exp_hit   = 1'b0;
    exp_rdata = '0;
    lfsr      = 16'd16;
    for (int s = 0; s < `CACHE_SETS; s++) begin
      sh_lru[s] = 1'b0;
      for (int i = 0; i < `CACHE_WAYS; i++) begin
        sh_valid[s][i] = 1'b0;
        sh_tag[s][i]   = '0;
      end
    end
    for (int i = 0; i < mem_words; i++)
      sh_mem[i] = '0;

    n = 0;
    @(negedge clk);
    while (reset) begin
      if (n == wait_limit) abort_run("reset was never released");
      n++;
      @(negedge clk);
    end

    check_value("ready", ready, 1);
    check_value("resp.valid", resp.valid, 0);
    check_value("mem_req.valid", dut.mem_req.valid, 0);
    end_test(1, "reset state");

    access(1'b0, 32'h024, '0);  // Cold miss
    access(1'b0, 32'h024, '0);
    end_test(2, "read miss then hit");

    access(1'b1, 32'h028, 32'hcafe_0001);
    access(1'b0, 32'h028, '0);
    end_test(3, "write hit then read");

    // A, B and A again in set 3, then C pushes out B
    access(1'b0, 32'h030, '0);
    access(1'b0, 32'h0b0, '0);
    access(1'b0, 32'h030, '0);
    access(1'b0, 32'h130, '0);
    access(1'b0, 32'h030, '0);
    access(1'b0, 32'h0b0, '0);
    end_test(4, "LRU replacement");

    access(1'b1, 32'h054, 32'h1234_5678);  // Dirty after the write miss
    access(1'b0, 32'h0d4, '0);
    access(1'b0, 32'h154, '0);             // Forces the write-back
    access(1'b0, 32'h054, '0);
    end_test(5, "dirty eviction");

    for (int i = 0; i < 200; i++) begin
      take_bits(1, r);
      w = r[0];
      take_bits(10, r);
      a = {20'b0, r[9:0], 2'b00};  // Whole backing memory
      take_bits(32, r);
      d = r;
      access(w, a, d);
    end
    end_test(6, "random mix");

    $display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+design
design/cache_pkg.sv
design/mem_pkg.sv
design/cache_tag_array.sv
design/cache_data_array.sv
design/cache_ctrl.sv
design/data_memory.sv
design/cache_top.sv
testbench/clock_gen.sv
testbench/cache_tb.sv
